// File: build.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/seqDivider.sv
verilog/alu.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/cpuTop.sv
bench/cpuTb_asserts.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build the simulation with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module cpuTb -o cpuTbSim \
    && ./obj_dir/cpuTbSim | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTb;

    localparam int MEM_WORDS    = 1 << `ADDR_W;
    localparam int RUN_LIMIT    = 40000;    // Cycles allowed per program.
    localparam int QUIET_WINDOW = 40;
    localparam int DATA_BASE    = 'h100;
    localparam int STORE_BASE   = 'h200;

    logic               clk, reset, req, ack, halted;
    logic [`WORD_W-1:0] rdata;
    cpuPkg::memReqT     memReq;

    logic [31:0]        lfsr = 32'h4525;
    logic [`WORD_W-1:0] mem [MEM_WORDS];
    logic [`WORD_W-1:0] prog [$];
    logic [`ADDR_W-1:0] expAddr [$];
    logic [`ADDR_W-1:0] actAddr [$];
    logic [`WORD_W-1:0] expData [$];
    logic [`WORD_W-1:0] actData [$];
    logic [`WORD_W-1:0] mRegs [`NUM_REGS];     // Reference model state.
    logic [`WORD_W-1:0] mHi, mLo;
    int                 errCount, testCount, failCount, nextStore;
    int                 memPhase, memCnt;

    cpuTop cpuTop_inst
    (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .memReq (memReq),
        .ack    (ack),
        .rdata  (rdata),
        .halted (halted)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic serveAccess();
        if (memReq.write)
        begin
            mem[memReq.addr] = memReq.wdata;
            actAddr.push_back(memReq.addr);
            actData.push_back(memReq.wdata);
        end
        else
            rdata <= mem[memReq.addr];
        ack      <= 1'b1;
        memPhase = 2;
    endtask

    // Memory side of the four-phase handshake, 0 to 3 wait cycles per phase.
    always @(posedge clk)
    begin
        case (memPhase)
            0:
            begin
                if (req)
                begin
                    memCnt = randBits(2);
                    if (memCnt == 0)
                        serveAccess();
                    else
                        memPhase = 1;
                end
            end
            1:
            begin
                memCnt--;
                if (memCnt == 0)
                    serveAccess();
            end
            2:
            begin
                if (!req)
                begin
                    memCnt = randBits(2);
                    if (memCnt == 0)
                    begin
                        ack      <= 1'b0;
                        memPhase = 0;
                    end
                    else
                        memPhase = 3;
                end
            end
            default:
            begin
                memCnt--;
                if (memCnt == 0)
                begin
                    ack      <= 1'b0;
                    memPhase = 0;
                end
            end
        endcase
    end

    // Append one instruction and run it on the model.
    task automatic emit(input cpuPkg::opcodeT op, input int ra, input int rb,
                        input int rc, input int addr);
        logic [`WORD_W-1:0] a, b;
        longint             qa, qb, wide;
        prog.push_back({op, 4'(ra), 4'(rb), 4'(rc), 15'(addr)});
        a = mRegs[ra];
        b = mRegs[rb];
        qa = $signed(a);
        qb = $signed(b);
        case (op)
            cpuPkg::opLd:   mRegs[rc] = mem[addr];
            cpuPkg::opSt:
            begin
                expAddr.push_back(`ADDR_W'(addr));
                expData.push_back(a);
            end
            cpuPkg::opAdd:  mRegs[rc] = a + b;     // Wraps at 32 bits.
            cpuPkg::opSub:  mRegs[rc] = a - b;
            cpuPkg::opAnd:  mRegs[rc] = a & b;
            cpuPkg::opOr:   mRegs[rc] = a | b;
            cpuPkg::opMul:
            begin
                wide = qa * qb;
                mLo  = wide[31:0];
                mHi  = wide[63:32];
            end
            cpuPkg::opDiv:
            begin
                if (b == '0)
                begin
                    mLo = '1;
                    mHi = a;
                end
                else
                begin
                    mLo = 32'(qa / qb);        // Truncates toward zero.
                    mHi = 32'(qa % qb);
                end
            end
            cpuPkg::opMfhi: mRegs[rc] = mHi;
            cpuPkg::opMflo: mRegs[rc] = mLo;
            default: ;
        endcase
    endtask

    task automatic storeReg(input int r);
        emit(cpuPkg::opSt, r, 0, 0, STORE_BASE + nextStore);
        nextStore++;
    endtask

    task automatic beginTest();
        @(posedge clk);
        reset <= 1'b1;
        prog.delete();
        expAddr.delete();
        expData.delete();
        actAddr.delete();
        actData.delete();
        nextStore = 0;
        mHi = '0;
        mLo = '0;
        for (int r = 0; r < `NUM_REGS; r++)
            mRegs[r] = '0;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = {a[15:0] ^ 16'hA5C3, ~a[15:0]};
        for (int i = 0; i < 8; i++)
            mem[DATA_BASE + i] = randBits(32);
    endtask

    task automatic loadData();
        for (int i = 0; i < 8; i++)
            emit(cpuPkg::opLd, 0, 0, i, DATA_BASE + i);
    endtask

    task automatic runTest(input string name);
        int cycles, errsBefore;
        errsBefore = errCount;
        emit(cpuPkg::opHalt, 0, 0, 0, 0);
        foreach (prog[i])
            mem[i] = prog[i];
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!halted)
        begin
            $display("test %s: CPU did not reach halt within %0d cycles", name, RUN_LIMIT);
            errCount++;
        end
        else
        begin
            for (int i = 0; i < QUIET_WINDOW; i++)
            begin
                @(posedge clk);
                assert (!req && halted)
                else
                begin
                    $display("test %s: memory request or halt change after halt", name);
                    errCount++;
                end
            end
            assert (actAddr.size() == expAddr.size())
            else
            begin
                $display("[ERROR] %s store count expected %0d actual %0d",
                         name, expAddr.size(), actAddr.size());
                errCount++;
            end
            for (int i = 0; i < expAddr.size() && i < actAddr.size(); i++)
            begin
                assert (actAddr[i] == expAddr[i] && actData[i] == expData[i])
                else
                begin
                    $display("[ERROR] %s store %0d expected %h@%h actual %h@%h", name, i,
                             expData[i], expAddr[i], actData[i], actAddr[i]);
                    errCount++;
                end
            end
        end
        testCount++;
        if (errCount != errsBefore)
            failCount++;
        $display("test %s: %0d stores, %0d cycles, %s", name, actAddr.size(), cycles,
                 (errCount == errsBefore) ? "ok" : "mismatch");
    endtask

    task automatic randomOps(input int count, input int kinds);
        cpuPkg::opcodeT op;
        int             rc;
        for (int i = 0; i < count; i++)
        begin
            case (randBits(3) % kinds)
                0: op = cpuPkg::opAdd;
                1: op = cpuPkg::opSub;
                2: op = cpuPkg::opAnd;
                3: op = cpuPkg::opOr;
                4: op = cpuPkg::opMul;
                default: op = cpuPkg::opDiv;
            endcase
            rc = randBits(4);
            emit(op, randBits(4), randBits(4), rc, 0);
            if (op == cpuPkg::opMul || op == cpuPkg::opDiv)
            begin
                emit(cpuPkg::opMflo, 0, 0, rc, 0);
                emit(cpuPkg::opMfhi, 0, 0, (rc + 1) % `NUM_REGS, 0);
                storeReg(rc);
                storeReg((rc + 1) % `NUM_REGS);
            end
            else
                storeReg(rc);
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        ack       = 1'b0;
        rdata     = '0;
        memPhase  = 0;
        errCount  = 0;
        testCount = 0;
        failCount = 0;

        beginTest();
        loadData();
        for (int i = 0; i < 8; i++)
            storeReg(i);
        runTest("ldst");

        beginTest();
        loadData();
        randomOps(24, 4);
        runTest("alu");

        beginTest();
        loadData();
        randomOps(16, 6);
        runTest("muldiv");

        beginTest();
        mem[DATA_BASE]     = 32'h144EA4EA;
        mem[DATA_BASE + 3] = 32'h0;
        loadData();
        emit(cpuPkg::opDiv, 0, 1, 0, 0);
        emit(cpuPkg::opMflo, 0, 0, 8, 0);
        emit(cpuPkg::opMfhi, 0, 0, 9, 0);
        storeReg(8);
        storeReg(9);
        emit(cpuPkg::opDiv, 2, 3, 0, 0);  // Divide by zero.
        emit(cpuPkg::opMflo, 0, 0, 10, 0);
        emit(cpuPkg::opMfhi, 0, 0, 11, 0);
        storeReg(10);
        storeReg(11);
        // Pin the reference quotient independently of the model.
        mem[DATA_BASE + 1] = 32'hFFFFFF38;
        expData[0] = 32'hFFE601BD;
        expData[1] = 32'h00000092;
        expData[2] = 32'hFFFFFFFF;
        expData[3] = mem[DATA_BASE + 2];
        runTest("divref");

        for (int t = 0; t < 3; t++)
        begin
            beginTest();
            loadData();
            randomOps(20, 6);
            runTest($sformatf("mixed%0d", t));
        end

        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/cpuTb_asserts.sv
`timescale 1ns/1ps

module cpuTbAsserts
(
    input logic           clk,
    input logic           reset,
    input logic           req,
    input logic           ack,
    input logic           memWrite,
    input cpuPkg::dpCtrlT ctrl,
    input logic           halted
);

    // A new request only starts once the previous ack has gone low.
    reqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
        (!req && ack) |=> !req)
        else $error("req raised while ack still high");

    // The access direction holds for the whole request.
    reqStable: assert property (@(posedge clk) disable iff (reset)
        (req && $past(req)) |-> (memWrite == $past(memWrite)))
        else $error("memory request changed while req high");

    // MAR and MDR keep the request's address and data until req drops.
    reqAddrDataHeld: assert property (@(posedge clk) disable iff (reset)
        req |-> (!ctrl.marIn && !(ctrl.mdrIn && !ctrl.mdrRead)))
        else $error("MAR or MDR loaded from the bus while req high");

    busOneDriver: assert property (@(posedge clk) disable iff (reset)
        $countones({ctrl.rOut, ctrl.pcOut, ctrl.mdrOut, ctrl.zHighOut,
                    ctrl.zLowOut, ctrl.hiOut, ctrl.loOut, ctrl.addrOut}) <= 1)
        else $error("more than one bus driver enabled");

    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

endmodule

bind controlUnit cpuTbAsserts cpuTbAsserts_inst
(
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .memWrite (memWrite),
    .ctrl     (ctrl),
    .halted   (halted)
);

// File: verilog/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTop
(
    input  logic               clk,
    input  logic               reset,
    output logic               req,
    output cpuPkg::memReqT     memReq,
    input  logic               ack,
    input  logic [`WORD_W-1:0] rdata,
    output logic               halted
);

    cpuPkg::dpCtrlT ctrl;
    cpuPkg::irT     ir;
    logic           divStart, divDone, memWrite;

    controlUnit controlUnit_inst
    (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .divStart (divStart),
        .ir       (ir),
        .divDone  (divDone),
        .req      (req),
        .ack      (ack),
        .memWrite (memWrite),
        .halted   (halted)
    );

    // The datapath sees ack directly so MDR grabs rdata on its first cycle.
    datapath datapath_inst
    (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .divStart (divStart),
        .divDone  (divDone),
        .ir       (ir),
        .memWrite (memWrite),
        .memReq   (memReq),
        .ackSeen  (ack),
        .rdata    (rdata)
    );

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlUnit
(
    input  logic           clk,
    input  logic           reset,
    output cpuPkg::dpCtrlT ctrl,
    output logic           divStart,
    input  cpuPkg::irT     ir,
    input  logic           divDone,
    output logic           req,
    input  logic           ack,
    output logic           memWrite,
    output logic           halted
);

    cpuPkg::stateT state, nextState, retState, accRet;
    logic          startAcc, armWrite, divBusy;

    function automatic cpuPkg::aluOpT aluOpFor(input cpuPkg::opcodeT opc);
        case (opc)
            cpuPkg::opSub: return cpuPkg::aluSub;
            cpuPkg::opAnd: return cpuPkg::aluAnd;
            cpuPkg::opOr:  return cpuPkg::aluOr;
            cpuPkg::opMul: return cpuPkg::aluMul;
            cpuPkg::opDiv: return cpuPkg::aluDiv;
            default:       return cpuPkg::aluAdd;
        endcase
    endfunction

    always_comb
    begin
        ctrl      = '0;
        divStart  = 1'b0;
        nextState = state;
        startAcc  = 1'b0;
        accRet    = cpuPkg::sFetch0;
        armWrite  = 1'b0;
        case (state)
            cpuPkg::sFetch0:
            begin
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.zIn   = 1'b1;
                ctrl.aluOp = cpuPkg::aluInc;
                nextState  = cpuPkg::sFetch1;
            end
            cpuPkg::sFetch1:
            begin
                ctrl.zLowOut = 1'b1;
                ctrl.pcIn    = 1'b1;
                startAcc     = 1'b1;    // Instruction read, MAR already settled.
                accRet       = cpuPkg::sFetch2;
                nextState    = cpuPkg::sMemWait;
            end
            cpuPkg::sMemWait:
            begin
                ctrl.mdrIn   = !memWrite;
                ctrl.mdrRead = 1'b1;
                if (ack)
                    nextState = cpuPkg::sMemRel;
            end
            cpuPkg::sMemRel:
            begin
                if (!ack)
                    nextState = retState;
            end
            cpuPkg::sFetch2:
            begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn   = 1'b1;
                nextState   = cpuPkg::sExec3;
            end
            cpuPkg::sExec3:
            begin
                nextState = cpuPkg::sExec4;
                case (ir.opcode)
                    cpuPkg::opLd, cpuPkg::opSt:
                    begin
                        ctrl.addrOut = 1'b1;
                        ctrl.marIn   = 1'b1;
                    end
                    cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                    cpuPkg::opMul, cpuPkg::opDiv:
                    begin
                        ctrl.rOut   = 1'b1;
                        ctrl.regSel = ir.ra;
                        ctrl.yIn    = 1'b1;
                    end
                    cpuPkg::opMfhi, cpuPkg::opMflo:
                    begin
                        ctrl.hiOut  = (ir.opcode == cpuPkg::opMfhi);
                        ctrl.loOut  = (ir.opcode == cpuPkg::opMflo);
                        ctrl.rIn    = 1'b1;
                        ctrl.regSel = ir.rc;
                        nextState   = cpuPkg::sFetch0;
                    end
                    default: nextState = cpuPkg::sHalted;  // halt and unknown opcodes.
                endcase
            end
            cpuPkg::sExec4:
            begin
                nextState = cpuPkg::sExec5;
                case (ir.opcode)
                    cpuPkg::opLd:
                    begin
                        startAcc  = 1'b1;
                        accRet    = cpuPkg::sExec5;
                        nextState = cpuPkg::sMemWait;
                    end
                    cpuPkg::opSt:
                    begin
                        ctrl.rOut   = 1'b1;
                        ctrl.regSel = ir.ra;
                        ctrl.mdrIn  = 1'b1;
                        armWrite    = 1'b1;
                    end
                    cpuPkg::opDiv:
                    begin
                        ctrl.rOut   = 1'b1;
                        ctrl.regSel = ir.rb;
                        ctrl.aluOp  = cpuPkg::aluDiv;
                        divStart    = !divBusy;
                        ctrl.zIn    = divDone;  // Hold here until the quotient is ready.
                        if (!divDone)
                            nextState = cpuPkg::sExec4;
                    end
                    cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                    cpuPkg::opMul:
                    begin
                        ctrl.rOut   = 1'b1;
                        ctrl.regSel = ir.rb;
                        ctrl.zIn    = 1'b1;
                        ctrl.aluOp  = aluOpFor(ir.opcode);
                    end
                    default: nextState = cpuPkg::sHalted;
                endcase
            end
            cpuPkg::sExec5:
            begin
                nextState = cpuPkg::sFetch0;
                case (ir.opcode)
                    cpuPkg::opLd:
                    begin
                        ctrl.mdrOut = 1'b1;
                        ctrl.rIn    = 1'b1;
                        ctrl.regSel = ir.rc;
                    end
                    cpuPkg::opSt:
                    begin
                        startAcc  = 1'b1;   // MDR and the write flag settled last cycle.
                        nextState = cpuPkg::sMemWait;
                    end
                    cpuPkg::opMul, cpuPkg::opDiv:
                    begin
                        ctrl.zLowOut = 1'b1;
                        ctrl.loIn    = 1'b1;
                        nextState    = cpuPkg::sExec6;
                    end
                    cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr:
                    begin
                        ctrl.zLowOut = 1'b1;
                        ctrl.rIn     = 1'b1;
                        ctrl.regSel  = ir.rc;
                    end
                    default: nextState = cpuPkg::sHalted;
                endcase
            end
            cpuPkg::sExec6:
            begin
                ctrl.zHighOut = 1'b1;
                ctrl.hiIn     = 1'b1;
                nextState     = cpuPkg::sFetch0;
            end
            default: nextState = cpuPkg::sHalted;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= cpuPkg::sFetch0;
            retState <= cpuPkg::sFetch0;
            req      <= 1'b0;
            memWrite <= 1'b0;
            divBusy  <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (startAcc)
            begin
                req      <= 1'b1;
                retState <= accRet;
            end
            else if (state == cpuPkg::sMemWait && ack)
                req <= 1'b0;
            // Every instruction fetch is a read.
            if (state == cpuPkg::sFetch0)
                memWrite <= 1'b0;
            else if (armWrite)
                memWrite <= 1'b1;
            if (divStart)
                divBusy <= 1'b1;
            else if (divDone)
                divBusy <= 1'b0;
        end
    end

    assign halted = (state == cpuPkg::sHalted);

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath
(
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::dpCtrlT     ctrl,
    input  logic               divStart,
    output logic               divDone,
    output cpuPkg::irT         ir,
    input  logic               memWrite,
    output cpuPkg::memReqT     memReq,
    input  logic               ackSeen,
    input  logic [`WORD_W-1:0] rdata
);

    logic [`WORD_W-1:0]   bus, regOut, addrExt;
    logic [`WORD_W-1:0]   pc, mdr, yReg, hiReg, loReg;
    logic [`ADDR_W-1:0]   mar;
    logic [2*`WORD_W-1:0] zReg, aluResult;

    assign addrExt = {{(`WORD_W-`ADDR_FLD_W){1'b0}}, ir.addr};

    regFile regFile_inst
    (
        .clk    (clk),
        .reset  (reset),
        .sel    (ctrl.regSel),
        .load   (ctrl.rIn),
        .busIn  (bus),
        .busOut (regOut)
    );

    alu alu_inst
    (
        .clk      (clk),
        .reset    (reset),
        .op       (ctrl.aluOp),
        .a        (yReg),
        .b        (bus),
        .divStart (divStart),
        .result   (aluResult),
        .divDone  (divDone)
    );

    // Bus mux, at most one driver is enabled.
    always_comb
    begin
        if (ctrl.rOut)          bus = regOut;
        else if (ctrl.pcOut)    bus = pc;
        else if (ctrl.mdrOut)   bus = mdr;
        else if (ctrl.zHighOut) bus = zReg[2*`WORD_W-1:`WORD_W];
        else if (ctrl.zLowOut)  bus = zReg[`WORD_W-1:0];
        else if (ctrl.hiOut)    bus = hiReg;
        else if (ctrl.loOut)    bus = loReg;
        else if (ctrl.addrOut)  bus = addrExt;
        else                    bus = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc    <= '0;
            ir    <= '0;
            mar   <= '0;
            mdr   <= '0;
            yReg  <= '0;
            zReg  <= '0;
            hiReg <= '0;
            loReg <= '0;
        end
        else
        begin
            if (ctrl.pcIn)  pc    <= bus;
            if (ctrl.irIn)  ir    <= cpuPkg::irT'(bus);
            if (ctrl.marIn) mar   <= bus[`ADDR_W-1:0];
            if (ctrl.yIn)   yReg  <= bus;
            if (ctrl.zIn)   zReg  <= aluResult;
            if (ctrl.hiIn)  hiReg <= bus;
            if (ctrl.loIn)  loReg <= bus;
            if (ctrl.mdrIn)
            begin
                if (!ctrl.mdrRead)
                    mdr <= bus;
                else if (ackSeen)
                    mdr <= rdata;   // Read data is valid while ack is high.
            end
        end
    end

    assign memReq = '{addr: mar, wdata: mdr, write: memWrite};

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu
(
    input  logic                 clk,
    input  logic                 reset,
    input  cpuPkg::aluOpT        op,
    input  logic [`WORD_W-1:0]   a,
    input  logic [`WORD_W-1:0]   b,
    input  logic                 divStart,
    output logic [2*`WORD_W-1:0] result,
    output logic                 divDone
);

    logic [`WORD_W-1:0]          quotient, remainder;
    logic [`WORD_W-1:0]          lowWord;
    logic signed [2*`WORD_W-1:0] product;

    // a is Y, b is the bus.
    assign product = $signed(a) * $signed(b);

    seqDivider seqDivider_inst
    (
        .clk       (clk),
        .reset     (reset),
        .start     (divStart),
        .dividend  (a),
        .divisor   (b),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (divDone)
    );

    always_comb
    begin
        case (op)
            cpuPkg::aluAdd: lowWord = a + b;
            cpuPkg::aluSub: lowWord = a - b;
            cpuPkg::aluAnd: lowWord = a & b;
            cpuPkg::aluOr:  lowWord = a | b;
            cpuPkg::aluInc: lowWord = b + 1'b1;     // PC increment during fetch.
            default:        lowWord = b;
        endcase

        case (op)
            cpuPkg::aluMul: result = product;
            cpuPkg::aluDiv: result = {remainder, quotient};
            default:
            begin
                // Single-word results are sign-extended into ZHigh.
                result = {{`WORD_W{lowWord[`WORD_W-1]}}, lowWord};
            end
        endcase
    end

endmodule

// File: verilog/seqDivider.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module seqDivider
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [`WORD_W-1:0] dividend,
    input  logic [`WORD_W-1:0] divisor,
    output logic [`WORD_W-1:0] quotient,
    output logic [`WORD_W-1:0] remainder,
    output logic               done
);

    localparam int STEPS = `WORD_W;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic               busy;
    logic [CNT_W-1:0]   stepCnt;
    logic [`WORD_W-1:0] remMag, quoMag, dvsMag, dividendHold;
    logic               negQuo, negRem, divZero;
    logic [`WORD_W:0]   shifted, trial;

    // One restoring step: shift in the next dividend bit and try the subtract.
    assign shifted = {remMag, quoMag[`WORD_W-1]};
    assign trial   = shifted - {1'b0, dvsMag};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            stepCnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy    <= 1'b1;
                stepCnt <= CNT_W'(STEPS);
            end
            else if (busy && stepCnt != '0)
                stepCnt <= stepCnt - 1'b1;
            else if (busy)
            begin
                busy <= 1'b0;       // Fix-up cycle, then done.
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            remMag       <= '0;
            quoMag       <= dividend[`WORD_W-1] ? -dividend : dividend;
            dvsMag       <= divisor[`WORD_W-1] ? -divisor : divisor;
            negQuo       <= dividend[`WORD_W-1] ^ divisor[`WORD_W-1];
            negRem       <= dividend[`WORD_W-1];   // Remainder follows the dividend.
            divZero      <= (divisor == '0);
            dividendHold <= dividend;
        end
        else if (busy && stepCnt != '0)
        begin
            if (!trial[`WORD_W])
            begin
                remMag <= trial[`WORD_W-1:0];
                quoMag <= {quoMag[`WORD_W-2:0], 1'b1};
            end
            else
            begin
                remMag <= shifted[`WORD_W-1:0];    // Restore.
                quoMag <= {quoMag[`WORD_W-2:0], 1'b0};
            end
        end
        else if (busy)
        begin
            if (divZero)
            begin
                quotient  <= '1;
                remainder <= dividendHold;
            end
            else
            begin
                quotient  <= negQuo ? -quoMag : quoMag;
                remainder <= negRem ? -remMag : remMag;
            end
        end
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`REG_SEL_W-1:0] sel,
    input  logic                  load,
    input  logic [`WORD_W-1:0]    busIn,
    output logic [`WORD_W-1:0]    busOut
);

    logic [`WORD_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (load)
        begin
            regs[sel] <= busIn;     // Rx_in from the bus.
        end
    end

    // Read side goes straight onto the bus mux.
    assign busOut = regs[sel];

endmodule

// File: verilog/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [`OPC_MSB-`OPC_LSB:0]
    {
        opLd   = 5'd0,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opMul  = 5'd15,
        opDiv  = 5'd16,
        opMfhi = 5'd24,
        opMflo = 5'd25,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [3:0]
    {
        sFetch0, sFetch1, sFetch2, sExec3, sExec4, sExec5, sExec6,
        sMemWait, sMemRel, sHalted
    } stateT;

    typedef enum logic [2:0]
    {
        aluAdd, aluSub, aluAnd, aluOr, aluMul, aluDiv, aluInc, aluPass
    } aluOpT;

    typedef struct packed
    {
        logic rIn, pcIn, irIn, marIn, mdrIn, mdrRead, yIn, zIn, hiIn, loIn;
        logic rOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, addrOut;
        aluOpT aluOp;
        logic [`REG_SEL_W-1:0] regSel;
    } dpCtrlT;

    typedef struct packed
    {
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] wdata;
        logic               write;
    } memReqT;

    // Overlay of the 32-bit IR.
    typedef struct packed
    {
        opcodeT                 opcode;
        logic [`REG_SEL_W-1:0]  ra;
        logic [`REG_SEL_W-1:0]  rb;
        logic [`REG_SEL_W-1:0]  rc;
        logic [`ADDR_FLD_W-1:0] addr;
    } irT;

endpackage

// File: verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W      32      // Data word width.
`define ADDR_W      16      // Word address width, MAR and memory port.
`define NUM_REGS    16
`define REG_SEL_W   4

// Instruction word layout.
`define OPC_MSB     31
`define OPC_LSB     27
`define RA_LSB      23
`define RB_LSB      19
`define RC_LSB      15
`define ADDR_LSB    0

// The ld/st address field stops below the Rc field, so the two never overlap.
`define ADDR_FLD_W  15

`endif
